// File: common/decode_pkg.sv
// ##########################################################
// Decoder outputs: ALU operation codes, operand selectors,
// control struct and the full decoded bundle
// ##########################################################
`default_nettype none

package decode_pkg;

    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_LUI,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_JAL,
        ALU_JALR,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_LB,
        ALU_LH,
        ALU_LW,
        ALU_LBU,
        ALU_LHU,
        ALU_SB,
        ALU_SH,
        ALU_SW
    } alu_code_e;

    // Where an ALU operand comes from
    typedef enum logic [1:0] {
        OPSEL_NONE = 2'd0,
        OPSEL_REG  = 2'd1,
        OPSEL_IMM  = 2'd2,
        OPSEL_PC   = 2'd3
    } operand_sel_e;

    typedef struct packed {
        alu_code_e    alu_code;
        operand_sel_e op1_sel;
        operand_sel_e op2_sel;
        logic         reg_we;
        logic         is_load;
        logic         is_store;
    } ctrl_t;  // 13 bits

    typedef struct packed {
        riscv_pkg::reg_num_t rs1;
        riscv_pkg::reg_num_t rs2;
        riscv_pkg::reg_num_t rd;
        riscv_pkg::xlen_t    imm;
        ctrl_t               ctrl;
    } decoded_t;  // 60 bits

endpackage

`default_nettype wire

// File: common/riscv_pkg.sv
// ##########################################################
// RV32I encodings: field widths, field types, major opcodes
// and the instruction format used for operand extraction
// ##########################################################
`default_nettype none

package riscv_pkg;

    // Field widths
    localparam int ILEN      = 32;
    localparam int XLEN      = 32;
    localparam int REG_NUM_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;

    typedef logic [ILEN-1:0]      instr_t;    // Raw instruction word
    typedef logic [XLEN-1:0]      xlen_t;     // Data word, used for imm
    typedef logic [REG_NUM_W-1:0] reg_num_t;  // x0..x31
    typedef logic [OPCODE_W-1:0]  opcode_t;   // instr[6:0]
    typedef logic [FUNCT3_W-1:0]  funct3_t;   // instr[14:12]

    // Major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // Instruction format, selects register fields and immediate layout
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,  // Unassigned encoding
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } inst_fmt_e;

endpackage

`default_nettype wire

// File: decoder/ctrl_decode.sv
// ##########################################################
// Control decode: opcode, funct3 and bit 30 to ALU code,
// operand selectors, flags and instruction format
// ##########################################################
`default_nettype none

module ctrl_decode (
    input  riscv_pkg::instr_t    instr,
    input  riscv_pkg::reg_num_t  rd,
    output riscv_pkg::inst_fmt_e fmt,
    output decode_pkg::ctrl_t    ctrl
);

    riscv_pkg::opcode_t       opcode;
    riscv_pkg::funct3_t       funct3;
    logic                     alt;  // instr[30], SUB and SRA
    logic                     legal;
    logic                     link;
    decode_pkg::alu_code_e    alu;
    decode_pkg::operand_sel_e op1;
    decode_pkg::operand_sel_e op2;
    logic                     we;
    logic                     ld;
    logic                     st;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    always_comb begin
        legal = 1'b1;
        link  = 1'b0;
        fmt   = riscv_pkg::FMT_NONE;
        alu   = decode_pkg::ALU_NOP;
        op1   = decode_pkg::OPSEL_NONE;
        op2   = decode_pkg::OPSEL_NONE;
        we    = 1'b0;
        ld    = 1'b0;
        st    = 1'b0;
        case (opcode)
            riscv_pkg::OPC_LUI: begin
                fmt = riscv_pkg::FMT_U;
                alu = decode_pkg::ALU_LUI;
                op2 = decode_pkg::OPSEL_IMM;
                we  = 1'b1;
            end
            riscv_pkg::OPC_AUIPC: begin
                fmt = riscv_pkg::FMT_U;
                alu = decode_pkg::ALU_ADD;  // imm + pc
                op1 = decode_pkg::OPSEL_IMM;
                op2 = decode_pkg::OPSEL_PC;
                we  = 1'b1;
            end
            riscv_pkg::OPC_JAL: begin
                fmt  = riscv_pkg::FMT_J;
                alu  = decode_pkg::ALU_JAL;
                op2  = decode_pkg::OPSEL_PC;
                we   = 1'b1;
                link = 1'b1;
            end
            riscv_pkg::OPC_JALR: begin
                fmt  = riscv_pkg::FMT_I;
                alu  = decode_pkg::ALU_JALR;
                op1  = decode_pkg::OPSEL_REG;
                op2  = decode_pkg::OPSEL_PC;
                we   = 1'b1;
                link = 1'b1;
            end
            riscv_pkg::OPC_BRANCH: begin
                fmt = riscv_pkg::FMT_B;
                op1 = decode_pkg::OPSEL_REG;
                op2 = decode_pkg::OPSEL_REG;
                case (funct3)
                    3'b000:  alu = decode_pkg::ALU_BEQ;
                    3'b001:  alu = decode_pkg::ALU_BNE;
                    3'b100:  alu = decode_pkg::ALU_BLT;
                    3'b101:  alu = decode_pkg::ALU_BGE;
                    3'b110:  alu = decode_pkg::ALU_BLTU;
                    3'b111:  alu = decode_pkg::ALU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            riscv_pkg::OPC_LOAD: begin
                fmt = riscv_pkg::FMT_I;
                op1 = decode_pkg::OPSEL_REG;
                op2 = decode_pkg::OPSEL_IMM;
                we  = 1'b1;
                ld  = 1'b1;
                case (funct3)
                    3'b000:  alu = decode_pkg::ALU_LB;
                    3'b001:  alu = decode_pkg::ALU_LH;
                    3'b010:  alu = decode_pkg::ALU_LW;
                    3'b100:  alu = decode_pkg::ALU_LBU;
                    3'b101:  alu = decode_pkg::ALU_LHU;
                    default: legal = 1'b0;
                endcase
            end
            riscv_pkg::OPC_STORE: begin
                fmt = riscv_pkg::FMT_S;
                op1 = decode_pkg::OPSEL_REG;
                op2 = decode_pkg::OPSEL_IMM;
                st  = 1'b1;
                case (funct3)
                    3'b000:  alu = decode_pkg::ALU_SB;
                    3'b001:  alu = decode_pkg::ALU_SH;
                    3'b010:  alu = decode_pkg::ALU_SW;
                    default: legal = 1'b0;
                endcase
            end
            riscv_pkg::OPC_OPIMM: begin
                fmt = riscv_pkg::FMT_I;
                op1 = decode_pkg::OPSEL_REG;
                op2 = decode_pkg::OPSEL_IMM;
                we  = 1'b1;
                case (funct3)
                    3'b000:  alu = decode_pkg::ALU_ADD;  // ADDI, no SUBI
                    3'b001:  alu = decode_pkg::ALU_SLL;
                    3'b010:  alu = decode_pkg::ALU_SLT;
                    3'b011:  alu = decode_pkg::ALU_SLTU;
                    3'b100:  alu = decode_pkg::ALU_XOR;
                    3'b101:  alu = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                    3'b110:  alu = decode_pkg::ALU_OR;
                    default: alu = decode_pkg::ALU_AND;
                endcase
            end
            riscv_pkg::OPC_OP: begin
                fmt = riscv_pkg::FMT_R;
                op1 = decode_pkg::OPSEL_REG;
                op2 = decode_pkg::OPSEL_REG;
                we  = 1'b1;
                case (funct3)
                    3'b000:  alu = alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
                    3'b001:  alu = decode_pkg::ALU_SLL;
                    3'b010:  alu = decode_pkg::ALU_SLT;
                    3'b011:  alu = decode_pkg::ALU_SLTU;
                    3'b100:  alu = decode_pkg::ALU_XOR;
                    3'b101:  alu = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                    3'b110:  alu = decode_pkg::ALU_OR;
                    default: alu = decode_pkg::ALU_AND;
                endcase
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // Any unassigned encoding collapses to the NOP bundle
        if (!legal) begin
            fmt  = riscv_pkg::FMT_NONE;
            alu  = decode_pkg::ALU_NOP;
            op1  = decode_pkg::OPSEL_NONE;
            op2  = decode_pkg::OPSEL_NONE;
            we   = 1'b0;
            ld   = 1'b0;
            st   = 1'b0;
            link = 1'b0;
        end
    end

    // Link to x0 writes nothing
    assign ctrl = '{
        alu_code: alu,
        op1_sel:  op1,
        op2_sel:  op2,
        reg_we:   we && !(link && (rd == 5'd0)),
        is_load:  ld,
        is_store: st
    };

endmodule

`default_nettype wire

// File: decoder/decode_stage.sv
// ##########################################################
// One-entry pipeline register for the decoded bundle,
// valid/ready on both sides
// ##########################################################
`default_nettype none

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::decoded_t in_dec,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::decoded_t out_dec
);

    logic load;

    // Free slot, or the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;  // Drops to 0 when drained with no new input
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_dec <= in_dec;
        end
    end

    // A stalled result stays valid and unchanged
    a_hold_stalled: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_dec)
    );

    a_empty_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    );

endmodule

`default_nettype wire

// File: decoder/decoder_top.sv
// ##########################################################
// RV32I decoder top: field extraction, control decode and
// the output pipeline register
// ##########################################################
`default_nettype none

module decoder_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  riscv_pkg::instr_t    in_instr,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::decoded_t out_dec
);

    riscv_pkg::inst_fmt_e fmt;
    riscv_pkg::reg_num_t  rs1;
    riscv_pkg::reg_num_t  rs2;
    riscv_pkg::reg_num_t  rd;
    riscv_pkg::xlen_t     imm;
    decode_pkg::ctrl_t    ctrl;
    decode_pkg::decoded_t dec;

    operand_fields fields0 (
        .instr (in_instr),
        .fmt   (fmt),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    ctrl_decode ctrl0 (
        .instr (in_instr),
        .rd    (rd),  // Gated by format, used for the x0 link rule
        .fmt   (fmt),
        .ctrl  (ctrl)
    );

    assign dec = '{rs1: rs1, rs2: rs2, rd: rd, imm: imm, ctrl: ctrl};

    decode_stage stage0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_dec    (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec)
    );

endmodule

`default_nettype wire

// File: decoder/operand_fields.sv
// ##########################################################
// Register number extraction and immediate assembly,
// both selected by the instruction format
// ##########################################################
`default_nettype none

module operand_fields (
    input  riscv_pkg::instr_t    instr,
    input  riscv_pkg::inst_fmt_e fmt,
    output riscv_pkg::reg_num_t  rs1,
    output riscv_pkg::reg_num_t  rs2,
    output riscv_pkg::reg_num_t  rd,
    output riscv_pkg::xlen_t     imm
);

    logic no_rs1;
    logic no_rs2;
    logic has_rd;

    // Unassigned encodings carry no register numbers at all
    assign no_rs1 = (fmt == riscv_pkg::FMT_U) ||
                    (fmt == riscv_pkg::FMT_J) ||
                    (fmt == riscv_pkg::FMT_NONE);
    assign no_rs2 = no_rs1 || (fmt == riscv_pkg::FMT_I);
    assign has_rd = (fmt == riscv_pkg::FMT_R) ||
                    (fmt == riscv_pkg::FMT_I) ||
                    (fmt == riscv_pkg::FMT_U) ||
                    (fmt == riscv_pkg::FMT_J);

    assign rs1 = no_rs1 ? 5'd0 : instr[19:15];
    assign rs2 = no_rs2 ? 5'd0 : instr[24:20];
    assign rd  = has_rd ? instr[11:7] : 5'd0;  // No rd for S and B

    always_comb begin
        case (fmt)
            riscv_pkg::FMT_U: begin
                imm = {instr[31:12], 12'd0};
            end
            riscv_pkg::FMT_J: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            riscv_pkg::FMT_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            riscv_pkg::FMT_B: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            riscv_pkg::FMT_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            default: begin
                imm = 32'd0;  // R format and NOP
            end
        endcase
    end

endmodule

`default_nettype wire

// File: project.f
common/riscv_pkg.sv
common/decode_pkg.sv
decoder/operand_fields.sv
decoder/ctrl_decode.sv
decoder/decode_stage.sv
decoder/decoder_top.sv
test/tb_decoder.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module tb_decoder -o sim_decoder
out=$(./obj_dir/sim_decoder)
echo "$out"
if grep -q "All tests passed!" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: test/tb_decoder.sv
// ##########################################################
// Directed testbench for decoder_top: instruction encoders,
// expected-bundle model, compare tasks and tests
// ##########################################################
`default_nettype none

module tb_decoder;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    riscv_pkg::instr_t    in_instr;
    logic                 out_valid;
    logic                 out_ready;
    decode_pkg::decoded_t out_dec;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] rng_state = 32'h5061_55a0;

    decoder_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Encoders, one per format
    function automatic riscv_pkg::instr_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic riscv_pkg::instr_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                                logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic riscv_pkg::instr_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                                logic [2:0] f3, logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic riscv_pkg::instr_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                                logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::OPC_BRANCH};
    endfunction

    function automatic riscv_pkg::instr_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic riscv_pkg::instr_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OPC_JAL};
    endfunction

    // ALU code of OP and OP-IMM, alt already qualified by funct3
    function automatic decode_pkg::alu_code_e arith_code(logic [2:0] f3, logic alt);
        case (f3)
            3'd0:    return alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'd1:    return decode_pkg::ALU_SLL;
            3'd2:    return decode_pkg::ALU_SLT;
            3'd3:    return decode_pkg::ALU_SLTU;
            3'd4:    return decode_pkg::ALU_XOR;
            3'd5:    return alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'd6:    return decode_pkg::ALU_OR;
            default: return decode_pkg::ALU_AND;
        endcase
    endfunction

    function automatic decode_pkg::decoded_t expect_dec(riscv_pkg::instr_t i);
        decode_pkg::decoded_t d;
        logic [2:0]           f3;
        logic                 r_fmt;
        logic                 i_fmt;
        logic                 s_fmt;
        logic                 b_fmt;
        logic                 u_fmt;
        logic                 j_fmt;
        d = '0;
        f3 = i[14:12];
        {r_fmt, i_fmt, s_fmt, b_fmt, u_fmt, j_fmt} = 6'b0;
        case (i[6:0])
            riscv_pkg::OPC_LUI: begin
                u_fmt = 1'b1;
                d.ctrl = '{decode_pkg::ALU_LUI, decode_pkg::OPSEL_NONE, decode_pkg::OPSEL_IMM,
                           1'b1, 1'b0, 1'b0};
            end
            riscv_pkg::OPC_AUIPC: begin
                u_fmt = 1'b1;
                d.ctrl = '{decode_pkg::ALU_ADD, decode_pkg::OPSEL_IMM, decode_pkg::OPSEL_PC,
                           1'b1, 1'b0, 1'b0};
            end
            riscv_pkg::OPC_JAL: begin
                j_fmt = 1'b1;
                d.ctrl = '{decode_pkg::ALU_JAL, decode_pkg::OPSEL_NONE, decode_pkg::OPSEL_PC,
                           i[11:7] != 5'd0, 1'b0, 1'b0};
            end
            riscv_pkg::OPC_JALR: begin
                i_fmt = 1'b1;
                d.ctrl = '{decode_pkg::ALU_JALR, decode_pkg::OPSEL_REG, decode_pkg::OPSEL_PC,
                           i[11:7] != 5'd0, 1'b0, 1'b0};
            end
            riscv_pkg::OPC_BRANCH: begin
                b_fmt = (f3 != 3'd2) && (f3 != 3'd3);
                case (f3)
                    3'd0:    d.ctrl.alu_code = decode_pkg::ALU_BEQ;
                    3'd1:    d.ctrl.alu_code = decode_pkg::ALU_BNE;
                    3'd4:    d.ctrl.alu_code = decode_pkg::ALU_BLT;
                    3'd5:    d.ctrl.alu_code = decode_pkg::ALU_BGE;
                    3'd6:    d.ctrl.alu_code = decode_pkg::ALU_BLTU;
                    3'd7:    d.ctrl.alu_code = decode_pkg::ALU_BGEU;
                    default: d.ctrl.alu_code = decode_pkg::ALU_NOP;
                endcase
                if (b_fmt) begin
                    d.ctrl.op1_sel = decode_pkg::OPSEL_REG;
                    d.ctrl.op2_sel = decode_pkg::OPSEL_REG;
                end
            end
            riscv_pkg::OPC_LOAD: begin
                i_fmt = (f3 != 3'd3) && (f3 < 3'd6);
                case (f3)
                    3'd0:    d.ctrl.alu_code = decode_pkg::ALU_LB;
                    3'd1:    d.ctrl.alu_code = decode_pkg::ALU_LH;
                    3'd2:    d.ctrl.alu_code = decode_pkg::ALU_LW;
                    3'd4:    d.ctrl.alu_code = decode_pkg::ALU_LBU;
                    3'd5:    d.ctrl.alu_code = decode_pkg::ALU_LHU;
                    default: d.ctrl.alu_code = decode_pkg::ALU_NOP;
                endcase
                if (i_fmt) begin
                    d.ctrl.op1_sel = decode_pkg::OPSEL_REG;
                    d.ctrl.op2_sel = decode_pkg::OPSEL_IMM;
                    d.ctrl.reg_we  = 1'b1;
                    d.ctrl.is_load = 1'b1;
                end
            end
            riscv_pkg::OPC_STORE: begin
                s_fmt = f3 < 3'd3;
                case (f3)
                    3'd0:    d.ctrl.alu_code = decode_pkg::ALU_SB;
                    3'd1:    d.ctrl.alu_code = decode_pkg::ALU_SH;
                    3'd2:    d.ctrl.alu_code = decode_pkg::ALU_SW;
                    default: d.ctrl.alu_code = decode_pkg::ALU_NOP;
                endcase
                if (s_fmt) begin
                    d.ctrl.op1_sel  = decode_pkg::OPSEL_REG;
                    d.ctrl.op2_sel  = decode_pkg::OPSEL_IMM;
                    d.ctrl.is_store = 1'b1;
                end
            end
            riscv_pkg::OPC_OPIMM: begin
                i_fmt = 1'b1;
                d.ctrl = '{arith_code(f3, i[30] && (f3 == 3'd5)), decode_pkg::OPSEL_REG,
                           decode_pkg::OPSEL_IMM, 1'b1, 1'b0, 1'b0};
            end
            riscv_pkg::OPC_OP: begin
                r_fmt = 1'b1;
                d.ctrl = '{arith_code(f3, i[30] && (f3 == 3'd0 || f3 == 3'd5)),
                           decode_pkg::OPSEL_REG, decode_pkg::OPSEL_REG, 1'b1, 1'b0, 1'b0};
            end
            default: d = '0;
        endcase
        if (r_fmt || i_fmt || s_fmt || b_fmt) d.rs1 = i[19:15];
        if (r_fmt || s_fmt || b_fmt) d.rs2 = i[24:20];
        if (r_fmt || i_fmt || u_fmt || j_fmt) d.rd = i[11:7];
        if (u_fmt) d.imm = {i[31:12], 12'd0};
        if (j_fmt) d.imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        if (i_fmt) d.imm = {{20{i[31]}}, i[31:20]};
        if (b_fmt) d.imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        if (s_fmt) d.imm = {{20{i[31]}}, i[31:25], i[11:7]};
        return d;
    endfunction

    task automatic compare_ctrl(decode_pkg::ctrl_t got, decode_pkg::ctrl_t exp, string name);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_dec(decode_pkg::decoded_t got, decode_pkg::decoded_t exp, string name);
        if (got.rs1 !== exp.rs1 || got.rs2 !== exp.rs2 || got.rd !== exp.rd
                || got.imm !== exp.imm) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
        compare_ctrl(got.ctrl, exp.ctrl, {name, ".ctrl"});
    endtask

    task automatic fail(string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    // Hands one instruction over; returns 10 units after the transfer edge
    task automatic push(riscv_pkg::instr_t instr);
        int n;
        n = 0;
        in_instr = instr;
        in_valid = 1'b1;
        while (!in_ready && n < 20) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (!in_ready) fail("in_ready stayed low for 20 cycles");
        @(posedge clk);
        #10;
        in_valid = 1'b0;
    endtask

    task automatic wait_out();
        int n;
        n = 0;
        while (!out_valid && n < 20) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (!out_valid) fail("out_valid never rose within 20 cycles");
    endtask

    // Lets a held result leave so the register starts empty
    task automatic drain_out();
        int n;
        n = 0;
        out_ready = 1'b1;
        while (out_valid && n < 20) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (out_valid) fail("out_valid stayed high for 20 cycles with out_ready high");
    endtask

    task automatic decode_check(riscv_pkg::instr_t instr, string name);
        push(instr);
        wait_out();
        compare_dec(out_dec, expect_dec(instr), name);
    endtask

    task automatic end_test(string name, int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_reset_latency();
        int e0;
        e0 = errors;
        if (out_valid !== 1'b0) fail("out_valid is not low after reset");
        if (in_ready !== 1'b1) fail("in_ready is not high after reset");
        push(enc_i(12'h123, 5'd1, 3'd0, 5'd2, riscv_pkg::OPC_OPIMM));
        if (out_valid !== 1'b1) fail("out_valid not high one cycle after the transfer");
        compare_dec(out_dec, expect_dec(in_instr), "out_dec");
        end_test("reset_latency", e0);
    endtask

    task automatic test_fields();
        int          e0;
        logic [31:0] r;
        logic [31:0] s;
        e0 = errors;
        repeat (6) begin
            r = xorshift();
            s = xorshift();
            decode_check(enc_u(r[31:12], s[4:0], riscv_pkg::OPC_LUI), "lui");
            decode_check(enc_j({r[20:1], 1'b0}, s[9:5]), "jal");
            decode_check(enc_i(r[11:0], s[4:0], 3'd0, s[14:10], riscv_pkg::OPC_OPIMM), "addi");
            decode_check(enc_b({r[12:1], 1'b0}, s[19:15], s[24:20], 3'd0), "beq");
            decode_check(enc_s(r[31:20], s[4:0], s[9:5], 3'd2, riscv_pkg::OPC_STORE), "sw");
        end
        end_test("fields", e0);
    endtask

    task automatic test_ctrl_table();
        int          e0;
        logic [31:0] r;
        e0 = errors;
        r = xorshift();
        decode_check(enc_u(r[19:0], 5'd3, riscv_pkg::OPC_AUIPC), "auipc");
        decode_check(enc_i(r[11:0], 5'd4, 3'd0, 5'd5, riscv_pkg::OPC_JALR), "jalr");
        for (int f = 0; f < 8; f++) begin
            r = xorshift();
            if (f != 2 && f != 3) decode_check(enc_b(r[12:0], 5'd6, 5'd7, 3'(f)), "branch");
            if (f != 3 && f < 6)
                decode_check(enc_i(r[11:0], 5'd8, 3'(f), 5'd9, riscv_pkg::OPC_LOAD), "load");
            if (f < 3)
                decode_check(enc_s(r[11:0], 5'd10, 5'd11, 3'(f), riscv_pkg::OPC_STORE),
                             "store");
            decode_check(enc_i({1'b0, r[10:0]}, 5'd12, 3'(f), 5'd13, riscv_pkg::OPC_OPIMM),
                         "opimm");
            decode_check(enc_r(7'h00, 5'd14, 5'd15, 3'(f), 5'd16, riscv_pkg::OPC_OP), "op");
        end
        decode_check(enc_i(12'h005, 5'd1, 3'd5, 5'd2, riscv_pkg::OPC_OPIMM), "srli");
        decode_check(enc_i(12'h405, 5'd1, 3'd5, 5'd2, riscv_pkg::OPC_OPIMM), "srai");
        decode_check(enc_r(7'h20, 5'd3, 5'd4, 3'd0, 5'd5, riscv_pkg::OPC_OP), "sub");
        decode_check(enc_r(7'h20, 5'd6, 5'd7, 3'd5, 5'd8, riscv_pkg::OPC_OP), "sra");
        end_test("ctrl_table", e0);
    endtask

    task automatic test_link_x0();
        int e0;
        e0 = errors;
        decode_check(enc_j(21'h00ff0, 5'd0), "jal x0");
        if (out_dec.ctrl.reg_we !== 1'b0) fail("jal to x0 sets reg_we");
        decode_check(enc_j(21'h00ff0, 5'd1), "jal x1");
        if (out_dec.ctrl.reg_we !== 1'b1) fail("jal to x1 clears reg_we");
        decode_check(enc_i(12'h010, 5'd1, 3'd0, 5'd0, riscv_pkg::OPC_JALR), "jalr x0");
        if (out_dec.ctrl.reg_we !== 1'b0) fail("jalr to x0 sets reg_we");
        decode_check(enc_i(12'h010, 5'd1, 3'd0, 5'd5, riscv_pkg::OPC_JALR), "jalr x5");
        if (out_dec.ctrl.reg_we !== 1'b1) fail("jalr to x5 clears reg_we");
        end_test("link_x0", e0);
    endtask

    task automatic illegal_check(riscv_pkg::instr_t instr, string name);
        push(instr);
        wait_out();
        compare_dec(out_dec, '0, name);  // NOP bundle is all zero
    endtask

    task automatic test_illegal();
        int e0;
        e0 = errors;
        illegal_check(32'hffff_ffff, "unknown opcode");
        illegal_check(enc_b(13'h0ffe, 5'd3, 5'd4, 3'd2), "branch f3=2");
        illegal_check(enc_i(12'h7ff, 5'd5, 3'd3, 5'd6, riscv_pkg::OPC_LOAD), "load f3=3");
        illegal_check(enc_s(12'h801, 5'd7, 5'd8, 3'd4, riscv_pkg::OPC_STORE), "store f3=4");
        end_test("illegal", e0);
    endtask

    task automatic test_stream();
        int                   e0;
        int                   sent;
        int                   got;
        logic                 in_fire;
        logic                 out_fire;
        logic                 prev_in_fire;
        logic                 held_chk;
        logic [31:0]          r;
        riscv_pkg::instr_t    burst[8];
        riscv_pkg::opcode_t   opcs[9];
        decode_pkg::decoded_t held;
        decode_pkg::decoded_t exp_q[$];
        e0 = errors;
        sent = 0;
        got = 0;
        prev_in_fire = 1'b0;
        held_chk = 1'b0;
        held = '0;
        opcs = '{riscv_pkg::OPC_LUI, riscv_pkg::OPC_AUIPC, riscv_pkg::OPC_JAL, riscv_pkg::OPC_JALR,
                 riscv_pkg::OPC_BRANCH, riscv_pkg::OPC_LOAD, riscv_pkg::OPC_STORE,
                 riscv_pkg::OPC_OPIMM, riscv_pkg::OPC_OP};
        foreach (burst[k]) begin
            r = xorshift();
            burst[k] = {r[31:7], opcs[r[7:0] % 9]};
        end
        drain_out();
        for (int cyc = 0; cyc < 60 && got < 8; cyc++) begin
            r = xorshift();
            out_ready = r[3];
            in_valid = sent < 8;
            in_instr = (sent < 8) ? burst[sent] : '0;
            #1;
            if (held_chk) begin
                if (!out_valid) fail("out_valid dropped while stalled");
                compare_dec(out_dec, held, "out_dec (stalled)");
            end
            if (prev_in_fire && !out_valid) fail("accepted item missing one cycle later");
            if (out_ready && !in_ready) fail("in_ready low while out_ready high");
            in_fire = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            held_chk = out_valid && !out_ready;
            held = out_dec;
            if (out_fire) begin
                compare_dec(out_dec, exp_q.pop_front(), "out_dec");
                got++;
            end
            if (in_fire) begin
                exp_q.push_back(expect_dec(burst[sent]));
                sent++;
            end
            prev_in_fire = in_fire;
            @(posedge clk);
            #10;
        end
        if (got < 8) fail("burst did not drain within 60 cycles");
        in_valid = 1'b0;
        out_ready = 1'b1;
        end_test("stream", e0);
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        test_reset_latency();
        test_fields();
        test_ctrl_table();
        test_link_x0();
        test_illegal();
        test_stream();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
